// ==== vlog.f ====
design/execute_pkg.sv
design/issue_decode.sv
design/fu_alu.sv
design/fu_scalar_ls.sv
design/fu_matrix_ls.sv
design/result_writeback.sv
design/execute.sv
tests/execute_checker.sv
tests/execute_tb.sv

// ==== Makefile ====
# Verilator flow for the execute stage

VERILATOR ?= verilator
TOP       ?= execute_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/execute_tb.sv ====
// Execute stage testbench, random instruction stream checked against a cycle model
`default_nettype none

module execute_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TXNS     = 3000;
    localparam int TIMEOUT      = (NUM_TXNS * 10 + 200) * CLK_PERIOD;

    logic                               CLK;
    logic                               reset;
    logic                               in_valid;
    logic [execute_pkg::WORD_W-1:0]     instr;
    logic [execute_pkg::WORD_W-1:0]     rs1_val;
    logic [execute_pkg::WORD_W-1:0]     rs2_val;
    logic                               wb_valid;
    logic [execute_pkg::REG_W-1:0]      wb_rd;
    logic [execute_pkg::WORD_W-1:0]     wb_data;
    logic                               wb_zero;
    logic                               wb_negative;
    logic                               wb_overflow;
    logic                               dmem_ren;
    logic                               dmem_wen;
    logic [execute_pkg::WORD_W-1:0]     dmem_addr;
    logic [execute_pkg::WORD_W-1:0]     dmem_store;
    logic                               mls_valid;
    logic                               mls_write;
    logic [execute_pkg::MREG_W-1:0]     mls_reg;
    logic [execute_pkg::ROW_W-1:0]      mls_row;
    logic [execute_pkg::WORD_W-1:0]     mls_addr;
    logic                               mls_done;

    int          cycle = 0;
    int          last_mat_edge = -100;
    int          error_count = 0;
    integer      seed;

    // Expected events, each tagged with the cycle it is due in
    int          wb_due[$];
    logic [39:0] wb_exp[$];
    int          dm_due[$];
    logic [65:0] dm_exp[$];
    int          mat_due[$];
    logic [39:0] mat_exp[$];

    execute UUT (
        .CLK(CLK), .reset(reset), .in_valid(in_valid), .instr(instr),
        .rs1_val(rs1_val), .rs2_val(rs2_val),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .wb_zero(wb_zero),
        .wb_negative(wb_negative), .wb_overflow(wb_overflow),
        .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
        .dmem_store(dmem_store),
        .mls_valid(mls_valid), .mls_write(mls_write), .mls_reg(mls_reg),
        .mls_row(mls_row), .mls_addr(mls_addr), .mls_done(mls_done)
    );

    bind fu_matrix_ls execute_checker MLS_CHK (
        .CLK(CLK), .reset(reset), .mls_start(mls_start), .busy(busy),
        .mls_valid(mls_valid), .mls_row(mls_row), .mls_done(mls_done)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    always @(posedge CLK) cycle <= cycle + 1;

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            error_count++;
            abort_run();
        end
    endtask

    // Returns {zero, negative, overflow, result}
    function automatic logic [34:0] alu_model(input logic [2:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [32:0] wide;
        logic [31:0] res;
        logic        ovf;
        wide = '0;
        res  = '0;
        ovf  = 1'b0;
        case (op)
            3'd0: begin
                wide = {a[31], a} + {b[31], b};
                res  = wide[31:0];
                ovf  = wide[32] ^ wide[31];
            end
            3'd1: begin
                wide = {a[31], a} - {b[31], b};
                res  = wide[31:0];
                ovf  = wide[32] ^ wide[31];
            end
            3'd2: res = a & b;
            3'd3: res = a | b;
            3'd4: res = a ^ b;
            3'd5: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd6: res = a << b[4:0];
            default: res = a >> b[4:0];
        endcase
        return {res == 32'd0, res[31], ovf, res};
    endfunction

    // Drives one random cycle and records what the DUT owes for it
    task automatic issue_random();
        logic [31:0] r;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] mimm;
        logic [34:0] alu;
        logic [3:0]  op;
        int          edge_n;
        int          row;
        r      = $random(seed);
        word   = $random(seed);
        a      = $random(seed);
        b      = $random(seed);
        // Cycle count that the next edge produces, the one that samples this drive
        edge_n = cycle + 1;
        if (r[3]) b = a;
        if (r[11:9] == 3'd0) word[27:23] = 5'd0;
        op = word[31:28];
        // Unused opcodes are mostly folded back onto ALU ops
        if (op > execute_pkg::OP_MST && r[4]) op = {1'b0, r[7:5]};
        if ((op == execute_pkg::OP_MLD || op == execute_pkg::OP_MST) &&
            (edge_n - last_mat_edge < 4)) op = execute_pkg::OP_LW;
        word[31:28] = op;
        simm = {{19{word[12]}}, word[12:0]};
        mimm = {{12{word[19]}}, word[19:0]};
        if (r[2:0] != 3'd0) begin
            if (op <= execute_pkg::OP_ADDI) begin
                if (op == execute_pkg::OP_ADDI) alu = alu_model(3'd0, a, simm);
                else alu = alu_model(op[2:0], a, b);
                if (word[27:23] != 5'd0) begin
                    wb_due.push_back(edge_n + 3);
                    wb_exp.push_back({word[27:23], alu[31:0], alu[34:32]});
                end
            end else if (op == execute_pkg::OP_LW || op == execute_pkg::OP_SW) begin
                dm_due.push_back(edge_n + 2);
                dm_exp.push_back({op == execute_pkg::OP_LW, op == execute_pkg::OP_SW,
                                  a + simm, b});
            end else if (op == execute_pkg::OP_MLD || op == execute_pkg::OP_MST) begin
                last_mat_edge = edge_n;
                for (row = 0; row < execute_pkg::MAT_ROWS; row++) begin
                    mat_due.push_back(edge_n + 2 + row);
                    mat_exp.push_back({op == execute_pkg::OP_MST, word[27:24], row[1:0],
                                       a + mimm + b * 32'(row),
                                       row == execute_pkg::MAT_ROWS - 1});
                end
            end
        end
        in_valid <= (r[2:0] != 3'd0);
        instr    <= word;
        rs1_val  <= a;
        rs2_val  <= b;
    endtask

    // Outputs are compared mid cycle, away from the driving edge
    always @(negedge CLK) begin
        logic [65:0] dm;
        logic [39:0] wb;
        logic [39:0] mat;
        logic        mat_hit;
        dm      = '0;
        wb      = '0;
        mat     = '0;
        mat_hit = 1'b0;
        if (cycle >= 1) begin
            if (wb_due.size() > 0 && wb_due[0] == cycle) begin
                wb = wb_exp.pop_front();
                void'(wb_due.pop_front());
                check_value("wb_valid", 64'(1), 64'(wb_valid));
                check_value("writeback", 64'(wb),
                            64'({wb_rd, wb_data, wb_zero, wb_negative, wb_overflow}));
            end else begin
                check_value("wb_valid", 64'(0), 64'(wb_valid));
            end
            if (dm_due.size() > 0 && dm_due[0] == cycle) begin
                dm = dm_exp.pop_front();
                void'(dm_due.pop_front());
                check_value("dmem_addr", 64'(dm[63:32]), 64'(dmem_addr));
                if (dm[64]) check_value("dmem_store", 64'(dm[31:0]), 64'(dmem_store));
            end
            check_value("dmem_ren_wen", 64'(dm[65:64]), 64'({dmem_ren, dmem_wen}));
            if (mat_due.size() > 0 && mat_due[0] == cycle) begin
                mat_hit = 1'b1;
                mat = mat_exp.pop_front();
                void'(mat_due.pop_front());
                check_value("matrix_row", 64'(mat),
                            64'({mls_write, mls_reg, mls_row, mls_addr, mls_done}));
            end
            check_value("mls_valid", 64'(mat_hit), 64'(mls_valid));
            check_value("mls_done", 64'(mat[0]), 64'(mls_done));
        end
    end

    initial begin
        seed     = 32'h584856f2;
        reset    = 1'b1;
        in_valid = 1'b0;
        instr    = '0;
        rs1_val  = '0;
        rs2_val  = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        reset <= 1'b0;
        repeat (NUM_TXNS) begin
            @(posedge CLK);
            issue_random();
        end
        @(posedge CLK);
        in_valid <= 1'b0;
        while (wb_due.size() + dm_due.size() + mat_due.size() > 0) @(posedge CLK);
        repeat (4) @(posedge CLK);
        if (error_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run();
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired before the test sequence finished");
        abort_run();
    end

endmodule

`default_nettype wire

// ==== tests/execute_checker.sv ====
// Matrix load/store checker, concurrent assertions on the tile sequencer
`default_nettype none

module execute_checker (
    input wire                           CLK,
    input wire                           reset,
    input wire                           mls_start,
    input wire                           busy,
    input wire                           mls_valid,
    input wire [execute_pkg::ROW_W-1:0]  mls_row,
    input wire                           mls_done
);

    // A new tile may only start as the previous one ends
    a_no_start_busy: assert property (
        @(posedge CLK) disable iff (reset) mls_start |-> (!busy || mls_done)
    ) else $error("matrix start issued while a tile is still in progress");

    // Done closes a tile that has been valid for every row
    a_done_valid: assert property (
        @(posedge CLK) disable iff (reset)
        mls_done |-> (mls_valid && $past(mls_valid, execute_pkg::MAT_ROWS - 1))
    ) else $error("matrix done raised without a full tile of valid rows");

    a_row_step: assert property (
        @(posedge CLK) disable iff (reset)
        (mls_valid && !mls_done) |=> (mls_valid && mls_row == $past(mls_row) + 1'b1)
    ) else $error("matrix row did not advance by one within a tile");

    // Synchronous reset clears the sequencer
    a_reset_idle: assert property (
        @(posedge CLK) reset |=> !mls_valid
    ) else $error("matrix valid high after a reset cycle");

endmodule

`default_nettype wire

// ==== design/execute.sv ====
// Execute stage top, decode then functional units then ALU writeback
`default_nettype none

module execute (
    input  wire                             CLK,
    input  wire                             reset,
    input  wire                             in_valid,
    input  wire  [execute_pkg::WORD_W-1:0]  instr,
    input  wire  [execute_pkg::WORD_W-1:0]  rs1_val,
    input  wire  [execute_pkg::WORD_W-1:0]  rs2_val,
    output logic                            wb_valid,
    output logic [execute_pkg::REG_W-1:0]   wb_rd,
    output logic [execute_pkg::WORD_W-1:0]  wb_data,
    output logic                            wb_zero,
    output logic                            wb_negative,
    output logic                            wb_overflow,
    output logic                            dmem_ren,
    output logic                            dmem_wen,
    output logic [execute_pkg::WORD_W-1:0]  dmem_addr,
    output logic [execute_pkg::WORD_W-1:0]  dmem_store,
    output logic                            mls_valid,
    output logic                            mls_write,
    output logic [execute_pkg::MREG_W-1:0]  mls_reg,
    output logic [execute_pkg::ROW_W-1:0]   mls_row,
    output logic [execute_pkg::WORD_W-1:0]  mls_addr,
    output logic                            mls_done
);

    // Decode to ALU
    logic                            alu_start;
    logic [execute_pkg::ALUOP_W-1:0] alu_op;
    logic [execute_pkg::WORD_W-1:0]  alu_a;
    logic [execute_pkg::WORD_W-1:0]  alu_b;
    logic [execute_pkg::REG_W-1:0]   alu_rd;

    // Decode to scalar load/store
    logic                            sls_start;
    logic                            sls_write;
    logic [execute_pkg::WORD_W-1:0]  sls_base;
    logic [execute_pkg::WORD_W-1:0]  sls_offset;
    logic [execute_pkg::WORD_W-1:0]  sls_data;

    // Decode to matrix load/store
    logic                            mls_start;
    logic                            mls_store;
    logic [execute_pkg::MREG_W-1:0]  mls_md;
    logic [execute_pkg::WORD_W-1:0]  mls_base;
    logic [execute_pkg::WORD_W-1:0]  mls_offset;
    logic [execute_pkg::WORD_W-1:0]  mls_stride;

    // ALU to writeback
    logic                            alu_valid;
    logic [execute_pkg::REG_W-1:0]   alu_rd_out;
    logic [execute_pkg::WORD_W-1:0]  alu_result;
    logic                            alu_zero;
    logic                            alu_negative;
    logic                            alu_overflow;

    issue_decode DEC (
        .CLK(CLK), .reset(reset), .in_valid(in_valid), .instr(instr),
        .rs1_val(rs1_val), .rs2_val(rs2_val),
        .alu_start(alu_start), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_rd(alu_rd),
        .sls_start(sls_start), .sls_write(sls_write), .sls_base(sls_base),
        .sls_offset(sls_offset), .sls_data(sls_data),
        .mls_start(mls_start), .mls_store(mls_store), .mls_md(mls_md),
        .mls_base(mls_base), .mls_offset(mls_offset), .mls_stride(mls_stride)
    );

    fu_alu SALU (
        .CLK(CLK), .reset(reset), .alu_start(alu_start), .alu_op(alu_op),
        .alu_a(alu_a), .alu_b(alu_b), .alu_rd(alu_rd),
        .alu_valid(alu_valid), .alu_rd_out(alu_rd_out), .alu_result(alu_result),
        .alu_zero(alu_zero), .alu_negative(alu_negative), .alu_overflow(alu_overflow)
    );

    fu_scalar_ls SLS (
        .CLK(CLK), .reset(reset), .sls_start(sls_start), .sls_write(sls_write),
        .sls_base(sls_base), .sls_offset(sls_offset), .sls_data(sls_data),
        .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
        .dmem_store(dmem_store)
    );

    fu_matrix_ls MLS (
        .CLK(CLK), .reset(reset), .mls_start(mls_start), .mls_store(mls_store),
        .mls_md(mls_md), .mls_base(mls_base), .mls_offset(mls_offset),
        .mls_stride(mls_stride),
        .mls_valid(mls_valid), .mls_write(mls_write), .mls_reg(mls_reg),
        .mls_row(mls_row), .mls_addr(mls_addr), .mls_done(mls_done)
    );

    result_writeback WB (
        .CLK(CLK), .reset(reset), .alu_valid(alu_valid), .alu_rd(alu_rd_out),
        .alu_result(alu_result), .alu_zero(alu_zero), .alu_negative(alu_negative),
        .alu_overflow(alu_overflow),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .wb_zero(wb_zero),
        .wb_negative(wb_negative), .wb_overflow(wb_overflow)
    );

endmodule

`default_nettype wire

// ==== design/result_writeback.sv ====
// Writeback stage, registers ALU results for the register file write port
`default_nettype none

module result_writeback (
    input  wire                             CLK,
    input  wire                             reset,
    input  wire                             alu_valid,
    input  wire  [execute_pkg::REG_W-1:0]   alu_rd,
    input  wire  [execute_pkg::WORD_W-1:0]  alu_result,
    input  wire                             alu_zero,
    input  wire                             alu_negative,
    input  wire                             alu_overflow,
    output logic                            wb_valid,
    output logic [execute_pkg::REG_W-1:0]   wb_rd,
    output logic [execute_pkg::WORD_W-1:0]  wb_data,
    output logic                            wb_zero,
    output logic                            wb_negative,
    output logic                            wb_overflow
);

    // Register 0 is hardwired, its writes vanish here
    always_ff @(posedge CLK) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= alu_valid && (alu_rd != '0);
        end
    end

    always_ff @(posedge CLK) begin
        if (alu_valid) begin
            wb_rd       <= alu_rd;
            wb_data     <= alu_result;
            wb_zero     <= alu_zero;
            wb_negative <= alu_negative;
            wb_overflow <= alu_overflow;
        end
    end

endmodule

`default_nettype wire

// ==== design/fu_matrix_ls.sv ====
// Matrix load/store unit, walks the row addresses of one tile at one row per cycle
`default_nettype none

module fu_matrix_ls (
    input  wire                             CLK,
    input  wire                             reset,
    input  wire                             mls_start,
    input  wire                             mls_store,
    input  wire  [execute_pkg::MREG_W-1:0]  mls_md,
    input  wire  [execute_pkg::WORD_W-1:0]  mls_base,
    input  wire  [execute_pkg::WORD_W-1:0]  mls_offset,
    input  wire  [execute_pkg::WORD_W-1:0]  mls_stride,
    output logic                            mls_valid,
    output logic                            mls_write,
    output logic [execute_pkg::MREG_W-1:0]  mls_reg,
    output logic [execute_pkg::ROW_W-1:0]   mls_row,
    output logic [execute_pkg::WORD_W-1:0]  mls_addr,
    output logic                            mls_done
);

    logic                            busy;
    logic [execute_pkg::ROW_W-1:0]   row;
    logic [execute_pkg::WORD_W-1:0]  stride;
    logic                            last_row;

    assign last_row = (row == execute_pkg::ROW_W'(execute_pkg::MAT_ROWS - 1));

    // Busy flag and row counter
    always_ff @(posedge CLK) begin
        if (reset) begin
            busy <= 1'b0;
            row  <= '0;
        end else if (mls_start) begin
            busy <= 1'b1;
            row  <= '0;
        end else if (busy) begin
            // Counter wraps back to row 0 as the tile ends
            busy <= !last_row;
            row  <= row + 1'b1;
        end
    end

    // Tile payload, address steps by the stride each row
    always_ff @(posedge CLK) begin
        if (mls_start) begin
            mls_addr  <= mls_base + mls_offset;
            stride    <= mls_stride;
            mls_write <= mls_store;
            mls_reg   <= mls_md;
        end else if (busy) begin
            mls_addr <= mls_addr + stride;
        end
    end

    assign mls_valid = busy;
    assign mls_row   = row;
    assign mls_done  = busy && last_row;

endmodule

`default_nettype wire

// ==== design/fu_scalar_ls.sv ====
// Scalar load/store unit, issues one data memory request per instruction
`default_nettype none

module fu_scalar_ls (
    input  wire                             CLK,
    input  wire                             reset,
    input  wire                             sls_start,
    input  wire                             sls_write,
    input  wire  [execute_pkg::WORD_W-1:0]  sls_base,
    input  wire  [execute_pkg::WORD_W-1:0]  sls_offset,
    input  wire  [execute_pkg::WORD_W-1:0]  sls_data,
    output logic                            dmem_ren,
    output logic                            dmem_wen,
    output logic [execute_pkg::WORD_W-1:0]  dmem_addr,
    output logic [execute_pkg::WORD_W-1:0]  dmem_store
);

    logic [execute_pkg::WORD_W-1:0] addr_d;

    // Effective address, wraps at 32 bits
    assign addr_d = sls_base + sls_offset;

    // One cycle strobes
    always_ff @(posedge CLK) begin
        if (reset) begin
            dmem_ren <= 1'b0;
            dmem_wen <= 1'b0;
        end else begin
            dmem_ren <= sls_start && !sls_write;
            dmem_wen <= sls_start && sls_write;
        end
    end

    // Address and data stay put until the next request
    always_ff @(posedge CLK) begin
        if (sls_start) begin
            dmem_addr  <= addr_d;
            dmem_store <= sls_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/fu_alu.sv ====
// Scalar ALU, registered result with zero, negative and signed overflow flags
`default_nettype none

module fu_alu (
    input  wire                              CLK,
    input  wire                              reset,
    input  wire                              alu_start,
    input  wire  [execute_pkg::ALUOP_W-1:0]  alu_op,
    input  wire  [execute_pkg::WORD_W-1:0]   alu_a,
    input  wire  [execute_pkg::WORD_W-1:0]   alu_b,
    input  wire  [execute_pkg::REG_W-1:0]    alu_rd,
    output logic                             alu_valid,
    output logic [execute_pkg::REG_W-1:0]    alu_rd_out,
    output logic [execute_pkg::WORD_W-1:0]   alu_result,
    output logic                             alu_zero,
    output logic                             alu_negative,
    output logic                             alu_overflow
);

    localparam int MSB = execute_pkg::WORD_W - 1;

    logic [execute_pkg::WORD_W-1:0] sum;
    logic [execute_pkg::WORD_W-1:0] diff;
    logic [execute_pkg::WORD_W-1:0] result_d;
    logic                           ovf_d;
    logic                           slt;

    assign sum  = alu_a + alu_b;
    assign diff = alu_a - alu_b;
    assign slt  = $signed(alu_a) < $signed(alu_b);

    always_comb begin
        result_d = '0;
        ovf_d    = 1'b0;
        case (alu_op)
            execute_pkg::OP_ADD[execute_pkg::ALUOP_W-1:0]: begin
                result_d = sum;
                ovf_d    = (alu_a[MSB] == alu_b[MSB]) && (sum[MSB] != alu_a[MSB]);
            end
            execute_pkg::OP_SUB[execute_pkg::ALUOP_W-1:0]: begin
                result_d = diff;
                ovf_d    = (alu_a[MSB] != alu_b[MSB]) && (diff[MSB] != alu_a[MSB]);
            end
            execute_pkg::OP_AND[execute_pkg::ALUOP_W-1:0]: result_d = alu_a & alu_b;
            execute_pkg::OP_OR[execute_pkg::ALUOP_W-1:0]:  result_d = alu_a | alu_b;
            execute_pkg::OP_XOR[execute_pkg::ALUOP_W-1:0]: result_d = alu_a ^ alu_b;
            execute_pkg::OP_SLT[execute_pkg::ALUOP_W-1:0]: result_d = {{MSB{1'b0}}, slt};
            // Shift amount from the low 5 bits only
            execute_pkg::OP_SLL[execute_pkg::ALUOP_W-1:0]: result_d = alu_a << alu_b[4:0];
            execute_pkg::OP_SRL[execute_pkg::ALUOP_W-1:0]: result_d = alu_a >> alu_b[4:0];
            default: result_d = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= alu_start;
        end
    end

    always_ff @(posedge CLK) begin
        if (alu_start) begin
            alu_rd_out   <= alu_rd;
            alu_result   <= result_d;
            alu_zero     <= (result_d == '0);
            alu_negative <= result_d[MSB];
            alu_overflow <= ovf_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/issue_decode.sv ====
// Issue decode, routes an instruction to one functional unit with registered operands
`default_nettype none

module issue_decode (
    input  wire                                CLK,
    input  wire                                reset,
    input  wire                                in_valid,
    input  wire  [execute_pkg::WORD_W-1:0]     instr,
    input  wire  [execute_pkg::WORD_W-1:0]     rs1_val,
    input  wire  [execute_pkg::WORD_W-1:0]     rs2_val,
    output logic                               alu_start,
    output logic [execute_pkg::ALUOP_W-1:0]    alu_op,
    output logic [execute_pkg::WORD_W-1:0]     alu_a,
    output logic [execute_pkg::WORD_W-1:0]     alu_b,
    output logic [execute_pkg::REG_W-1:0]      alu_rd,
    output logic                               sls_start,
    output logic                               sls_write,
    output logic [execute_pkg::WORD_W-1:0]     sls_base,
    output logic [execute_pkg::WORD_W-1:0]     sls_offset,
    output logic [execute_pkg::WORD_W-1:0]     sls_data,
    output logic                               mls_start,
    output logic                               mls_store,
    output logic [execute_pkg::MREG_W-1:0]     mls_md,
    output logic [execute_pkg::WORD_W-1:0]     mls_base,
    output logic [execute_pkg::WORD_W-1:0]     mls_offset,
    output logic [execute_pkg::WORD_W-1:0]     mls_stride
);

    execute_pkg::instr_word_u             iw;
    logic [execute_pkg::OPCODE_W-1:0]     opcode;
    logic [execute_pkg::WORD_W-1:0]       simm;
    logic [execute_pkg::WORD_W-1:0]       mimm;
    logic                                 is_rr;
    logic                                 is_addi;
    logic                                 is_sls;
    logic                                 is_mls;

    assign iw     = instr;
    assign opcode = iw.s.opcode;

    // Sign extended immediates of both layouts
    assign simm = {{(execute_pkg::WORD_W - execute_pkg::SIMM_W){iw.s.imm[execute_pkg::SIMM_W-1]}},
                   iw.s.imm};
    assign mimm = {{(execute_pkg::WORD_W - execute_pkg::MIMM_W){iw.m.imm[execute_pkg::MIMM_W-1]}},
                   iw.m.imm};

    // Unit selection, opcodes 13 to 15 match nothing
    assign is_rr   = (opcode <= execute_pkg::OP_SRL);
    assign is_addi = (opcode == execute_pkg::OP_ADDI);
    assign is_sls  = (opcode == execute_pkg::OP_LW) || (opcode == execute_pkg::OP_SW);
    assign is_mls  = (opcode == execute_pkg::OP_MLD) || (opcode == execute_pkg::OP_MST);

    always_ff @(posedge CLK) begin
        if (reset) begin
            alu_start <= 1'b0;
            sls_start <= 1'b0;
            mls_start <= 1'b0;
        end else begin
            alu_start <= in_valid && (is_rr || is_addi);
            sls_start <= in_valid && is_sls;
            mls_start <= in_valid && is_mls;
        end
    end

    // Operands only move when an instruction arrives
    always_ff @(posedge CLK) begin
        if (in_valid) begin
            alu_op     <= is_addi ? execute_pkg::OP_ADD[execute_pkg::ALUOP_W-1:0]
                                  : opcode[execute_pkg::ALUOP_W-1:0];
            alu_a      <= rs1_val;
            alu_b      <= is_addi ? simm : rs2_val;
            alu_rd     <= iw.s.rd;
            sls_write  <= (opcode == execute_pkg::OP_SW);
            sls_base   <= rs1_val;
            sls_offset <= simm;
            sls_data   <= rs2_val;
            mls_store  <= (opcode == execute_pkg::OP_MST);
            mls_md     <= iw.m.md;
            mls_base   <= rs1_val;
            mls_offset <= mimm;
            mls_stride <= rs2_val;
        end
    end

endmodule

`default_nettype wire

// ==== design/execute_pkg.sv ====
// Execute stage shared widths, opcodes, tile geometry and the instruction word layout
`default_nettype none

package execute_pkg;

    localparam int WORD_W   = 32;
    localparam int OPCODE_W = 4;
    localparam int REG_W    = 5;
    localparam int MREG_W   = 4;
    localparam int ALUOP_W  = 3;
    localparam int SIMM_W   = 13;
    localparam int MIMM_W   = 20;

    // Matrix tile geometry
    localparam int MAT_ROWS = 4;
    localparam int ROW_W    = 2;

    // Register-register ALU ops, low bits double as the ALU op code
    localparam logic [OPCODE_W-1:0] OP_ADD  = 4'd0;
    localparam logic [OPCODE_W-1:0] OP_SUB  = 4'd1;
    localparam logic [OPCODE_W-1:0] OP_AND  = 4'd2;
    localparam logic [OPCODE_W-1:0] OP_OR   = 4'd3;
    localparam logic [OPCODE_W-1:0] OP_XOR  = 4'd4;
    localparam logic [OPCODE_W-1:0] OP_SLT  = 4'd5;
    localparam logic [OPCODE_W-1:0] OP_SLL  = 4'd6;
    localparam logic [OPCODE_W-1:0] OP_SRL  = 4'd7;
    localparam logic [OPCODE_W-1:0] OP_ADDI = 4'd8;
    localparam logic [OPCODE_W-1:0] OP_LW   = 4'd9;
    localparam logic [OPCODE_W-1:0] OP_SW   = 4'd10;
    localparam logic [OPCODE_W-1:0] OP_MLD  = 4'd11;
    localparam logic [OPCODE_W-1:0] OP_MST  = 4'd12;

    // One instruction word, scalar or matrix layout
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0] opcode;
            logic [REG_W-1:0]    rd;
            logic [9:0]          rsvd;
            logic [SIMM_W-1:0]   imm;
        } s;
        struct packed {
            logic [OPCODE_W-1:0] opcode;
            logic [MREG_W-1:0]   md;
            logic [3:0]          rsvd;
            logic [MIMM_W-1:0]   imm;
        } m;
    } instr_word_u;

endpackage

`default_nettype wire
